/* compile.f */
src/fetch_pkg.sv
src/redirect_hold.sv
src/pc_gen.sv
src/fetch_hazard.sv
src/instr_buffer.sv
src/fetch_unit.sv
tb/fetch_unit_tb.sv

/* tb/fetch_input.txt */
# columns: wait cycles, kind, target or epc (hex), stall cycles, expected first pc (hex)
# kind 0 none, 1 branch, 2 trap, 3 eret, 4 trap plus branch
20 0 00000000 0 00000000
4 0 00000000 3 00000000
3 1 80001000 0 80001000
6 1 80002040 2 80002040
2 0 00000000 5 00000000
5 3 80000200 0 80000200
8 2 00000000 0 bfc00380
3 4 80003000 0 bfc00380
5 1 9fc01000 4 9fc01000
3 0 00000000 6 00000000
0 3 80004008 1 80004008
4 4 80005000 3 bfc00380
7 1 80006010 0 80006010
1 0 00000000 1 00000000
0 1 80007000 0 80007000
0 3 80008000 0 80008000
10 1 80000102 0 80000102
6 0 00000000 2 00000000
3 2 00000000 0 bfc00380
5 1 8000a000 2 8000a000
2 2 00000000 3 bfc00380
4 1 8000b006 3 8000b006
5 0 00000000 2 00000000
3 2 00000000 1 bfc00380
2 3 bfc00400 0 bfc00400
6 1 80010000 5 80010000
0 4 80011000 2 bfc00380
12 0 00000000 4 00000000
3 1 80012008 0 80012008
1 3 80013000 3 80013000
9 2 00000000 0 bfc00380
4 1 80014000 1 80014000
2 3 80015010 2 80015010
0 1 80016000 0 80016000
5 4 80017000 0 bfc00380
7 0 00000000 3 00000000
1 1 80018000 6 80018000
20 0 00000000 0 00000000

/* tb/fetch_unit_tb.sv */
`timescale 1ns/1ps

module fetch_unit_tb;

    logic clk;
    logic reset;
    logic stall;
    fetch_pkg::redirect_t redirect;
    fetch_pkg::ibus_req_t ireq;
    fetch_pkg::ibus_resp_t iresp;
    fetch_pkg::fetch_pair_t out_pair;

    // result counters
    int errors = 0;
    int timeouts = 0;
    int pair_count = 0;

    // reference model of the pair stream
    logic pending = 1'b0;
    fetch_pkg::word_t pending_target = '0;
    int inflight_left = 0;
    fetch_pkg::word_t exp_pc = fetch_pkg::RESET_PC;
    fetch_pkg::fetch_pair_t last_pair;

    // memory model
    logic [31:0] rng = 32'd9;
    logic bus_take;
    fetch_pkg::word_t bus_addr;
    fetch_pkg::ibus_req_t req_rule;

    // request seen one negedge earlier
    fetch_pkg::word_t prev_addr;
    logic prev_stall = 1'b0;

    // monitor samples
    logic edge_stall;
    logic edge_reset;

    // script fields
    int fd;
    int wait_n;
    int kind;
    int stall_n;
    fetch_pkg::word_t target;
    fetch_pkg::word_t expect_pc;
    logic [8*200-1:0] line;
    fetch_pkg::ibus_req_t reset_req;
    fetch_pkg::fetch_slot_t no_slot;

    fetch_unit UUT (
        .clk      (clk),
        .reset    (reset),
        .ireq     (ireq),
        .iresp    (iresp),
        .redirect (redirect),
        .stall    (stall),
        .out_pair (out_pair)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // word at address a is a with its top byte flipped
    function automatic fetch_pkg::word_t mem_word(input fetch_pkg::word_t a);
        return a ^ 32'hff00_0000;
    endfunction

    function automatic fetch_pkg::fetch_slot_t expected_slot(input fetch_pkg::word_t pc);
        fetch_pkg::fetch_slot_t s;
        s.valid = 1'b1;
        s.pc = pc;
        // misaligned fetch comes back empty
        s.bad_vaddr = |pc[1:0];
        s.instr = s.bad_vaddr ? '0 : mem_word(pc);
        return s;
    endfunction

    task automatic check_slot(input string name, input fetch_pkg::fetch_slot_t got,
                              input fetch_pkg::fetch_slot_t exp);
        // fields only matter on a valid slot
        if (got.valid !== exp.valid || (exp.valid && (got.pc !== exp.pc
                || got.instr !== exp.instr || got.bad_vaddr !== exp.bad_vaddr))) begin
            errors++;
            $display("[FAIL] %s got valid=%h pc=%h instr=%h bad=%h", name,
                got.valid, got.pc, got.instr, got.bad_vaddr);
            $display("[FAIL] %s expected valid=%h pc=%h instr=%h bad=%h", name,
                exp.valid, exp.pc, exp.instr, exp.bad_vaddr);
        end
    endtask

    task automatic check_req(input string name, input fetch_pkg::ibus_req_t got,
                             input fetch_pkg::ibus_req_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got valid=%h addr=%h expected valid=%h addr=%h", name,
                got.valid, got.addr, exp.valid, exp.addr);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // new pair is either the redirect target or the next sequential fetch
    task automatic score_pair();
        fetch_pkg::word_t got;
        fetch_pkg::word_t want;
        got = out_pair[0].pc;
        want = pending ? pending_target : exp_pc;
        if (pending && got === pending_target) begin
            pending = 1'b0;
        end else if (got === exp_pc && (!pending || inflight_left > 0)) begin
            // one older fetch may still drain after a redirect
            if (pending) begin
                inflight_left--;
            end
        end else begin
            errors++;
            $display("[FAIL] out_pair[0].pc got %h expected %h", got, want);
            pending = 1'b0;
        end
        exp_pc = got + fetch_pkg::FETCH_BYTES;
        pair_count++;
        check_slot("out_pair[0]", out_pair[0], expected_slot(got));
        check_slot("out_pair[1]", out_pair[1],
            expected_slot(got + fetch_pkg::INSTR_BYTES));
    endtask

    task automatic run_step(input int w, input int k, input fetch_pkg::word_t tgt,
                            input int s, input fetch_pkg::word_t exp_target);
        int n;
        fetch_pkg::redirect_t r;
        fetch_pkg::ibus_req_t bad_req;
        repeat (w) next_cycle();
        r = '0;
        case (k)
            1: begin
                r.branch_taken = 1'b1;
                r.branch_target = tgt;
            end
            2: r.trap = 1'b1;
            3: begin
                r.eret = 1'b1;
                r.epc = tgt;
            end
            4: begin
                r.trap = 1'b1;
                r.branch_taken = 1'b1;
                r.branch_target = tgt;
            end
            default: r = '0;
        endcase
        if (k != 0) begin
            pending = 1'b1;
            pending_target = exp_target;
            inflight_left = 1;
        end
        // one-cycle pulse with the stall starting alongside
        redirect = r;
        stall = (s > 0);
        next_cycle();
        redirect = '0;
        if (s > 1) begin
            repeat (s - 1) next_cycle();
        end
        stall = 1'b0;
        if (k != 0) begin
            n = 0;
            while (pending && n < 100) begin
                next_cycle();
                n++;
            end
            if (pending) begin
                timeouts++;
                $display("timed out waiting for the pair at %h", exp_target);
                pending = 1'b0;
            end else if (k == 1 && exp_target[1:0] != 2'b00 && s == 0) begin
                // bad pc never waits on the bus so the pc is two fetches past the target
                bad_req.valid = 1'b0;
                bad_req.addr = exp_target + 2 * fetch_pkg::FETCH_BYTES;
                check_req("ireq", ireq, bad_req);
            end
        end
    endtask

    // memory takes the request seen at the negedge and answers in the next cycle only
    initial begin
        iresp.addr_ok = 1'b0;
        iresp.data = '0;
        forever begin
            @(negedge clk);
            bus_take = ireq.valid && iresp.addr_ok;
            bus_addr = ireq.addr;
            if (!reset) begin
                req_rule.valid = (ireq.addr[1:0] == 2'b00);
                // pc register holds across a stalled edge
                req_rule.addr = prev_stall ? prev_addr : ireq.addr;
                check_req("ireq", ireq, req_rule);
            end
            prev_addr = ireq.addr;
            prev_stall = stall && !reset;
            @(posedge clk);
            #2;
            if (bus_take) begin
                iresp.data = {mem_word(bus_addr + fetch_pkg::INSTR_BYTES), mem_word(bus_addr)};
            end else begin
                iresp.data = 64'hdead_beef_dead_beef;
            end
            rng = xorshift(rng);
            iresp.addr_ok = (rng[1:0] != 2'b00);
        end
    end

    // pair monitor samples stall and reset before the edge
    initial begin
        forever begin
            @(negedge clk);
            edge_stall = stall;
            edge_reset = reset;
            @(posedge clk);
            #1;
            if (!edge_reset) begin
                if (edge_stall) begin
                    check_slot("out_pair[0] under stall", out_pair[0], last_pair[0]);
                    check_slot("out_pair[1] under stall", out_pair[1], last_pair[1]);
                end else if (out_pair[0].valid || out_pair[1].valid) begin
                    score_pair();
                end
            end
            last_pair = out_pair;
        end
    end

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        redirect = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        reset_req.valid = 1'b1;
        reset_req.addr = fetch_pkg::RESET_PC;
        check_req("ireq", ireq, reset_req);
        no_slot = '0;
        check_slot("out_pair[0]", out_pair[0], no_slot);
        check_slot("out_pair[1]", out_pair[1], no_slot);
        fd = $fopen("tb/fetch_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tb/fetch_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    // comment lines match no fields
                    if ($sscanf(line, "%d %d %h %d %h", wait_n, kind, target, stall_n,
                            expect_pc) == 5) begin
                        run_step(wait_n, kind, target, stall_n, expect_pc);
                    end
                end
            end
            $fclose(fd);
        end
        repeat (40) next_cycle();
        if (pair_count == 0) begin
            errors++;
            $display("no instruction pairs came out of the fetch unit");
        end
        $display("errors: %0d  timeouts: %0d  pairs: %0d", errors, timeouts, pair_count);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                   clk,
    input  logic                   reset,
    output fetch_pkg::ibus_req_t   ireq,
    input  fetch_pkg::ibus_resp_t  iresp,
    input  fetch_pkg::redirect_t   redirect,
    input  logic                   stall,
    output fetch_pkg::fetch_pair_t out_pair
);

    // pc stage
    fetch_pkg::word_t pc_selected;
    logic pc_bad;

    // pending redirect
    logic held_valid;
    fetch_pkg::word_t held_pc;

    // stage control
    logic p_advance;
    logic flush_f;

    pc_gen u_pc_gen (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .held_valid  (held_valid),
        .held_pc     (held_pc),
        .p_advance   (p_advance),
        .pc_selected (pc_selected),
        .ireq        (ireq),
        .pc_bad      (pc_bad)
    );

    redirect_hold u_redirect_hold (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .pc_selected (pc_selected),
        .p_advance   (p_advance),
        .held_valid  (held_valid),
        .held_pc     (held_pc)
    );

    fetch_hazard u_fetch_hazard (
        .redirect   (redirect),
        .held_valid (held_valid),
        .stall      (stall),
        .ireq       (ireq),
        .addr_ok    (iresp.addr_ok),
        .p_advance  (p_advance),
        .flush_f    (flush_f)
    );

    // fetch stage takes the pc register directly
    instr_buffer u_instr_buffer (
        .clk       (clk),
        .reset     (reset),
        .pc        (ireq.addr),
        .pc_bad    (pc_bad),
        .p_advance (p_advance),
        .flush_f   (flush_f),
        .stall     (stall),
        .data      (iresp.data),
        .out_pair  (out_pair)
    );

endmodule

/* src/instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::word_t       pc,
    input  logic                   pc_bad,
    input  logic                   p_advance,
    input  logic                   flush_f,
    input  logic                   stall,
    input  logic [63:0]            data,
    output fetch_pkg::fetch_pair_t out_pair
);

    // fetch stage contents
    typedef struct packed {
        logic valid;
        fetch_pkg::word_t pc;
        logic bad;
    } fstage_t;

    fstage_t fs;
    logic saved;
    logic [63:0] save_data;
    logic [63:0] use_data;
    logic save_now;
    fetch_pkg::fetch_pair_t pair_nxt;

    // fetch stage, one register behind the pc
    always_ff @(posedge clk) begin
        if (reset) begin
            fs.valid <= 1'b0;
        end else if (!stall) begin
            // bubble when the bus did not take it or a redirect is pending
            fs.valid <= p_advance && !flush_f;
            fs.pc <= pc;
            fs.bad <= pc_bad;
        end
    end

    // bus data lasts one cycle only,
    // so grab it on the first stalled cycle
    assign save_now = stall && fs.valid && !saved;

    always_ff @(posedge clk) begin
        if (reset) begin
            saved <= 1'b0;
        end else if (save_now) begin
            saved <= 1'b1;
        end else if (!stall) begin
            // stage moves on this edge
            saved <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (save_now) begin
            save_data <= data;
        end
    end

    assign use_data = saved ? save_data : data;

    // split into two slots
    always_comb begin
        pair_nxt[0].valid = fs.valid;
        pair_nxt[0].pc = fs.pc;
        pair_nxt[0].bad_vaddr = fs.bad;
        pair_nxt[0].instr = fs.bad ? '0 : use_data[31:0];

        pair_nxt[1].valid = fs.valid;
        pair_nxt[1].pc = fs.pc + fetch_pkg::INSTR_BYTES;
        // both slots carry the bad flag of the fetch
        pair_nxt[1].bad_vaddr = fs.bad;
        pair_nxt[1].instr = fs.bad ? '0 : use_data[63:32];
    end

    // output pair, frozen under stall
    always_ff @(posedge clk) begin
        if (reset) begin
            out_pair[0].valid <= 1'b0;
            out_pair[1].valid <= 1'b0;
        end else if (!stall) begin
            out_pair <= pair_nxt;
        end
    end

    // saved copy is dropped on the edge the stall ends
    a_saved_only_in_stall: assert property (@(posedge clk) disable iff (reset)
        !stall |=> !saved);

endmodule

/* src/fetch_hazard.sv */
`timescale 1ns/1ps

module fetch_hazard (
    input  fetch_pkg::redirect_t redirect,
    input  logic                 held_valid,
    input  logic                 stall,
    input  fetch_pkg::ibus_req_t ireq,
    input  logic                 addr_ok,
    output logic                 p_advance,
    output logic                 flush_f
);

    logic bus_wait;

    // request out but not taken yet
    assign bus_wait = ireq.valid && !addr_ok;

    // pc moves only when the bus took the address
    // and nothing downstream is stuck
    // bad-address fetch has no request, so it never waits on the bus
    assign p_advance = !stall && !bus_wait;

    // the fetch leaving the pc stage is on the wrong path
    // for any new or still pending redirect
    assign flush_f = redirect.trap
        || redirect.eret
        || redirect.branch_taken
        || held_valid;

    // stall must freeze the pc stage
    a_no_advance_in_stall: assert final (!(p_advance && stall))
        else $error("pc stage advanced during stall");

endmodule

/* src/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::redirect_t redirect,
    input  logic                 held_valid,
    input  fetch_pkg::word_t     held_pc,
    input  logic                 p_advance,
    output fetch_pkg::word_t     pc_selected,
    output fetch_pkg::ibus_req_t ireq,
    output logic                 pc_bad
);

    fetch_pkg::word_t pc;
    fetch_pkg::word_t pc_succ;
    fetch_pkg::word_t pc_nxt;

    // sequential fetch steps over both slots
    assign pc_succ = pc + fetch_pkg::FETCH_BYTES;

    // trap, then eret, then branch, then fall through
    always_comb begin
        if (redirect.trap) begin
            pc_selected = fetch_pkg::TRAP_ENTRY;
        end else if (redirect.eret) begin
            pc_selected = redirect.epc;
        end else if (redirect.branch_taken) begin
            pc_selected = redirect.branch_target;
        end else begin
            pc_selected = pc_succ;
        end
    end

    // target remembered during a stall wins
    assign pc_nxt = held_valid ? held_pc : pc_selected;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= fetch_pkg::RESET_PC;
        end else if (p_advance) begin
            pc <= pc_nxt;
        end
    end

    // misaligned pc sends no request
    assign pc_bad = |pc[1:0];
    assign ireq.valid = !pc_bad;
    assign ireq.addr = pc;

endmodule

/* src/redirect_hold.sv */
`timescale 1ns/1ps

module redirect_hold (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::redirect_t redirect,
    input  fetch_pkg::word_t     pc_selected,
    input  logic                 p_advance,
    output logic                 held_valid,
    output fetch_pkg::word_t     held_pc
);

    fetch_pkg::hold_state_e state;
    fetch_pkg::hold_state_e state_nxt;
    fetch_pkg::word_t saved_pc;
    logic exc;
    logic any_redirect;
    logic capture;

    // trap and eret share the higher-priority hold
    assign exc = redirect.trap || redirect.eret;
    assign any_redirect = exc || redirect.branch_taken;

    // a branch cannot displace a held trap target
    assign capture = !p_advance
        && (exc || (redirect.branch_taken && state != fetch_pkg::HOLD_TRAP));

    always_comb begin
        state_nxt = state;
        if (p_advance) begin
            // target goes into the pc on this edge
            state_nxt = fetch_pkg::HOLD_NONE;
        end else if (exc) begin
            state_nxt = fetch_pkg::HOLD_TRAP;
        end else if (redirect.branch_taken && state != fetch_pkg::HOLD_TRAP) begin
            state_nxt = fetch_pkg::HOLD_BRANCH;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch_pkg::HOLD_NONE;
        end else begin
            state <= state_nxt;
        end
    end

    // pc_selected already carries the redirect priority
    always_ff @(posedge clk) begin
        if (capture) begin
            saved_pc <= pc_selected;
        end
    end

    // a fresh redirect in the same cycle beats a held branch,
    // pc_gen then picks it up through pc_selected
    assign held_valid = (state == fetch_pkg::HOLD_TRAP)
        || (state == fetch_pkg::HOLD_BRANCH && !any_redirect);
    assign held_pc = saved_pc;

    // hold ends on the first advancing edge
    a_hold_released: assert property (@(posedge clk) disable iff (reset)
        p_advance |=> state == fetch_pkg::HOLD_NONE);

    a_trap_not_replaced: assert property (@(posedge clk) disable iff (reset)
        state == fetch_pkg::HOLD_TRAP |=> state != fetch_pkg::HOLD_BRANCH);

endmodule

/* src/fetch_pkg.sv */
package fetch_pkg;

    // one address or instruction word
    typedef logic [31:0] word_t;

    // reset vector and exception entry
    localparam word_t RESET_PC = 32'hbfc0_0000;
    localparam word_t TRAP_ENTRY = 32'hbfc0_0380;

    // one fetch is two instructions wide
    localparam word_t FETCH_BYTES = 32'd8;
    localparam word_t INSTR_BYTES = 32'd4;

    // instruction bus request, valid is a plain level
    typedef struct packed {
        logic valid;
        word_t addr;
    } ibus_req_t;

    // instruction bus response
    // low word of data sits at the lower address
    typedef struct packed {
        logic addr_ok;
        logic [63:0] data;
    } ibus_resp_t;

    // redirect pulses from the later stages
    typedef struct packed {
        logic trap;
        logic eret;
        logic branch_taken;
        word_t branch_target;
        word_t epc;
    } redirect_t;

    // one fetched instruction
    typedef struct packed {
        logic valid;
        word_t pc;
        word_t instr;
        logic bad_vaddr;
    } fetch_slot_t;

    // slot 0 is the older one at pc, slot 1 at pc+4
    typedef fetch_slot_t [1:0] fetch_pair_t;

    // pending redirect kept while the pc stage cannot move
    typedef enum logic [1:0] {
        HOLD_NONE,
        HOLD_TRAP,
        HOLD_BRANCH
    } hold_state_e;

endpackage
